// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f src.f --top-module tb_transmit_top -o tb_sim \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// ==== source/awg_player.sv ====
// Arbitrary waveform player, one frame memory per channel
// Channels replay in lockstep from a shared address that wraps at the frame end
`timescale 1ns/1ps
`default_nettype none
`include "tx_consts.svh"

module awg_player (
  input  wire                                 dac_clk_i,
  input  wire                                 rst_n_i,
  input  wire tx_pkg::awg_wr_t                awg_wr_i,
  input  wire                                 run_i,
  input  wire [`TX_AWG_ADDR_W-1:0]            last_addr_i,
  output tx_pkg::tx_beat_t [`TX_CHANNELS-1:0] beats_o,
  output logic                                frame_start_o
);

  // Frame memories, indexed by channel then beat
  logic [`TX_PAR_SAMPLES*`TX_SAMPLE_W-1:0] mem [`TX_CHANNELS][`TX_AWG_DEPTH];
  logic [`TX_AWG_ADDR_W-1:0]               addr_q;

  // Load port, accepted on every strobe
  always_ff @(posedge dac_clk_i) begin
    if (awg_wr_i.strobe) begin
      mem[awg_wr_i.channel][awg_wr_i.addr] <= awg_wr_i.data;
    end
  end

  // Shared read address
  // Frame start leaves with the address 0 beat
  always_ff @(posedge dac_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_q        <= '0;
      frame_start_o <= 1'b0;
    end else if (run_i) begin
      addr_q        <= (addr_q == last_addr_i) ? '0 : addr_q + 1'b1;
      frame_start_o <= (addr_q == '0);
    end else begin
      addr_q        <= '0;
      frame_start_o <= 1'b0;
    end
  end

  // Registered reads
  // Idle beats carry zero data and no valid
  always_ff @(posedge dac_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beats_o <= '0;
    end else begin
      for (int c = 0; c < `TX_CHANNELS; c++) begin
        if (run_i) begin
          beats_o[c].valid <= 1'b1;
          beats_o[c].data  <= mem[c][addr_q];
        end else begin
          beats_o[c] <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/channel_mux.sv ====
// Routes any AWG or DDS stream to each output channel
// One register stage, valid travels with its data
`timescale 1ns/1ps
`default_nettype none
`include "tx_consts.svh"

module channel_mux (
  input  wire                                     dac_clk_i,
  input  wire                                     rst_n_i,
  input  wire tx_pkg::tx_beat_t [2*`TX_CHANNELS-1:0] beats_i,
  input  wire tx_pkg::tx_cfg_t                    cfg_i,
  output tx_pkg::tx_beat_t [`TX_CHANNELS-1:0]     beats_o
);

  // Inputs 0..CH-1 are AWG, CH..2CH-1 are DDS
  // Several outputs may pick the same input
  always_ff @(posedge dac_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beats_o <= '0;
    end else begin
      for (int c = 0; c < `TX_CHANNELS; c++) begin
        beats_o[c] <= beats_i[cfg_i.mux_sel[c]];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/dac_prescaler.sv ====
// Per channel signed gain ahead of the DAC
// Product is shifted down by the scale fraction and saturated to 16 bits
`timescale 1ns/1ps
`default_nettype none
`include "tx_consts.svh"

module dac_prescaler (
  input  wire                                 dac_clk_i,
  input  wire                                 rst_n_i,
  input  wire tx_pkg::tx_beat_t [`TX_CHANNELS-1:0] beats_i,
  input  wire tx_pkg::tx_cfg_t                cfg_i,
  output tx_pkg::tx_beat_t [`TX_CHANNELS-1:0] beats_o
);
  import tx_pkg::*;

  localparam int PROD_W  = `TX_SAMPLE_W + `TX_SCALE_W;
  localparam int SHIFT_W = PROD_W - `TX_SCALE_FRAC;

  // Scale one sample, truncating toward minus infinity
  function automatic sample_t scale_sample(input sample_t sample,
                                           input logic signed [`TX_SCALE_W-1:0] scale);
    logic signed [PROD_W-1:0]             prod;
    logic signed [SHIFT_W-1:0]            shifted;
    logic [SHIFT_W-`TX_SAMPLE_W:0]        head;
    prod    = sample * scale;
    shifted = SHIFT_W'(prod >>> `TX_SCALE_FRAC);
    // Bits above the sample range must all match the sign
    head    = shifted[SHIFT_W-1:`TX_SAMPLE_W-1];
    if ((&head) || !(|head)) begin
      return shifted[`TX_SAMPLE_W-1:0];
    end else if (shifted[SHIFT_W-1]) begin
      return {1'b1, {(`TX_SAMPLE_W-1){1'b0}}};
    end else begin
      return {1'b0, {(`TX_SAMPLE_W-1){1'b1}}};
    end
  endfunction

  // Valid follows the data through the register
  always_ff @(posedge dac_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beats_o <= '0;
    end else begin
      for (int c = 0; c < `TX_CHANNELS; c++) begin
        beats_o[c].valid <= beats_i[c].valid;
        for (int k = 0; k < `TX_PAR_SAMPLES; k++) begin
          beats_o[c].data[k] <= scale_sample(beats_i[c].data[k], cfg_i.scale[c]);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/dds_sawtooth.sv ====
// Phase accumulator source producing a sawtooth per channel
// Parallel samples are spaced one phase increment apart
`timescale 1ns/1ps
`default_nettype none
`include "tx_consts.svh"

module dds_sawtooth (
  input  wire                                 dac_clk_i,
  input  wire                                 rst_n_i,
  input  wire tx_pkg::tx_cfg_t                cfg_i,
  output tx_pkg::tx_beat_t [`TX_CHANNELS-1:0] beats_o
);

  logic [`TX_CHANNELS-1:0][`TX_PHASE_W-1:0]                      phase_q;
  logic [`TX_CHANNELS-1:0][`TX_PAR_SAMPLES-1:0][`TX_PHASE_W-1:0] sample_phase;

  // Phase of each parallel sample within the beat
  always_comb begin
    for (int c = 0; c < `TX_CHANNELS; c++) begin
      for (int k = 0; k < `TX_PAR_SAMPLES; k++) begin
        sample_phase[c][k] = phase_q[c] + `TX_PHASE_W'(k) * cfg_i.phase_inc[c];
      end
    end
  end

  // Beat from the phase before the advance
  // Accumulator steps one increment per parallel sample
  always_ff @(posedge dac_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= '0;
      beats_o <= '0;
    end else begin
      for (int c = 0; c < `TX_CHANNELS; c++) begin
        beats_o[c].valid <= 1'b1;
        for (int k = 0; k < `TX_PAR_SAMPLES; k++) begin
          // Top bits as a signed sample
          beats_o[c].data[k] <= sample_phase[c][k][`TX_PHASE_W-1 -: `TX_SAMPLE_W];
        end
        if (cfg_i.phase_rst[c]) begin
          phase_q[c] <= '0;
        end else begin
          phase_q[c] <= phase_q[c] + `TX_PHASE_W'(`TX_PAR_SAMPLES) * cfg_i.phase_inc[c];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/transmit_top.sv ====
// Top level of the DAC transmit chain
// AWG and DDS sources feed the channel mux, then the prescaler drives the DAC
`timescale 1ns/1ps
`default_nettype none
`include "tx_consts.svh"

module transmit_top (
  input  wire                                      dac_clk_i,
  input  wire                                      rst_n_i,
  input  wire                                      reg_wr_i,
  input  wire tx_pkg::tx_reg_e                     reg_addr_i,
  input  wire [31:0]                               reg_wdata_i,
  input  wire tx_pkg::awg_wr_t                     awg_wr_i,
  output wire tx_pkg::tx_beat_t [`TX_CHANNELS-1:0] dac_data_o,
  output wire                                      dac_trigger_o,
  output wire                                      awg_busy_o
);
  import tx_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////
  wire tx_cfg_t                     cfg;
  wire                              awg_run;
  wire [`TX_AWG_ADDR_W-1:0]         frame_last_addr;
  wire                              frame_start;

  tx_ctrl i_ctrl (
    .dac_clk_i         (dac_clk_i),
    .rst_n_i           (rst_n_i),
    .reg_wr_i          (reg_wr_i),
    .reg_addr_i        (reg_addr_i),
    .reg_wdata_i       (reg_wdata_i),
    .frame_start_i     (frame_start),
    .cfg_o             (cfg),
    .awg_run_o         (awg_run),
    .frame_last_addr_o (frame_last_addr),
    .trigger_o         (dac_trigger_o),
    .busy_o            (awg_busy_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Signal chain
  //////////////////////////////////////////////////////////////////////
  wire tx_beat_t [`TX_CHANNELS-1:0]   awg_beats;
  wire tx_beat_t [`TX_CHANNELS-1:0]   dds_beats;
  wire tx_beat_t [2*`TX_CHANNELS-1:0] mux_in;
  wire tx_beat_t [`TX_CHANNELS-1:0]   mux_beats;

  awg_player i_awg (
    .dac_clk_i     (dac_clk_i),
    .rst_n_i       (rst_n_i),
    .awg_wr_i      (awg_wr_i),
    .run_i         (awg_run),
    .last_addr_i   (frame_last_addr),
    .beats_o       (awg_beats),
    .frame_start_o (frame_start)
  );

  dds_sawtooth i_dds (
    .dac_clk_i (dac_clk_i),
    .rst_n_i   (rst_n_i),
    .cfg_i     (cfg),
    .beats_o   (dds_beats)
  );

  // AWG on the low mux inputs, DDS above
  assign mux_in = {dds_beats, awg_beats};

  channel_mux i_mux (
    .dac_clk_i (dac_clk_i),
    .rst_n_i   (rst_n_i),
    .beats_i   (mux_in),
    .cfg_i     (cfg),
    .beats_o   (mux_beats)
  );

  dac_prescaler i_prescaler (
    .dac_clk_i (dac_clk_i),
    .rst_n_i   (rst_n_i),
    .beats_i   (mux_beats),
    .cfg_i     (cfg),
    .beats_o   (dac_data_o)
  );

endmodule

`default_nettype wire

// ==== source/tx_consts.svh ====
// Sizing constants for the DAC transmit chain
// Included by the type package and by every module that sizes logic
`ifndef TX_CONSTS_SVH
`define TX_CONSTS_SVH

// Channel layout
`define TX_CHANNELS    2
`define TX_PAR_SAMPLES 2
`define TX_SAMPLE_W    16

// DDS phase and prescaler fixed point
`define TX_PHASE_W     32
`define TX_SCALE_W     18
`define TX_SCALE_FRAC  16

// AWG frame memory and burst counter
`define TX_AWG_DEPTH   64
`define TX_AWG_ADDR_W  6
`define TX_BURST_W     16

// Derived select widths
`define TX_MUX_SEL_W   ($clog2(2*`TX_CHANNELS))
`define TX_CH_W        ($clog2(`TX_CHANNELS))

`endif

// ==== source/tx_ctrl.sv ====
// Register file, AWG play sequencer and trigger output of the transmit chain
// Decodes the register port and paces AWG frames against the burst length
`timescale 1ns/1ps
`default_nettype none
`include "tx_consts.svh"

module tx_ctrl (
  input  wire                                dac_clk_i,
  input  wire                                rst_n_i,
  input  wire                                reg_wr_i,
  input  wire tx_pkg::tx_reg_e               reg_addr_i,
  input  wire [31:0]                         reg_wdata_i,
  input  wire                                frame_start_i,
  output tx_pkg::tx_cfg_t                    cfg_o,
  output logic                               awg_run_o,
  output logic [`TX_AWG_ADDR_W-1:0]          frame_last_addr_o,
  output logic                               trigger_o,
  output logic                               busy_o
);
  import tx_pkg::*;

  // Configuration registers
  logic [`TX_CHANNELS-1:0][`TX_PHASE_W-1:0]   phase_inc_q;
  logic [`TX_CHANNELS-1:0][`TX_SCALE_W-1:0]   scale_q;
  logic [`TX_CHANNELS-1:0][`TX_MUX_SEL_W-1:0] mux_sel_q;
  logic                                       trig_en_q;
  logic [`TX_AWG_ADDR_W-1:0]                  frame_depth_q;
  logic [`TX_BURST_W-1:0]                     burst_len_q;

  // Sequencer state
  awg_state_e                                 state_q;
  logic [`TX_AWG_ADDR_W-1:0]                  rd_addr_q;
  logic [`TX_BURST_W-1:0]                     frame_cnt_q;
  logic [`TX_BURST_W:0]                       frames_seen;
  logic                                       cmd_wr;
  logic                                       cmd_start;
  logic                                       cmd_stop;
  logic                                       burst_done;

  //////////////////////////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge dac_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_inc_q   <= '0;
      scale_q       <= '0;
      mux_sel_q     <= '0;
      trig_en_q     <= 1'b0;
      frame_depth_q <= '0;
      burst_len_q   <= '0;
    end else if (reg_wr_i) begin
      case (reg_addr_i)
        REG_PHASE_INC0:  phase_inc_q[0] <= reg_wdata_i[`TX_PHASE_W-1:0];
        REG_PHASE_INC1:  phase_inc_q[1] <= reg_wdata_i[`TX_PHASE_W-1:0];
        REG_SCALE0:      scale_q[0] <= reg_wdata_i[`TX_SCALE_W-1:0];
        REG_SCALE1:      scale_q[1] <= reg_wdata_i[`TX_SCALE_W-1:0];
        REG_MUX_SEL:     mux_sel_q <= reg_wdata_i[`TX_CHANNELS*`TX_MUX_SEL_W-1:0];
        REG_TRIG_EN:     trig_en_q <= reg_wdata_i[0];
        REG_FRAME_DEPTH: frame_depth_q <= reg_wdata_i[`TX_AWG_ADDR_W-1:0];
        REG_BURST_LEN:   burst_len_q <= reg_wdata_i[`TX_BURST_W-1:0];
        default: ;
      endcase
    end
  end

  // Phase reset pulses straight from the write strobe
  // so the DDS clears on the same edge as the new increment lands
  always_comb begin
    cfg_o.phase_inc    = phase_inc_q;
    cfg_o.scale        = scale_q;
    cfg_o.mux_sel      = mux_sel_q;
    cfg_o.phase_rst[0] = reg_wr_i && (reg_addr_i == REG_PHASE_INC0);
    cfg_o.phase_rst[1] = reg_wr_i && (reg_addr_i == REG_PHASE_INC1);
  end

  //////////////////////////////////////////////////////////////////////
  // AWG sequencer
  //////////////////////////////////////////////////////////////////////
  assign cmd_wr    = reg_wr_i && (reg_addr_i == REG_AWG_CMD);
  assign cmd_start = cmd_wr && reg_wdata_i[0];
  assign cmd_stop  = cmd_wr && reg_wdata_i[1];

  // Frames begun so far: counted pulses, the pulse in flight,
  // and the frame whose address 0 is being read right now
  assign frames_seen = {1'b0, frame_cnt_q}
                     + (`TX_BURST_W+1)'(frame_start_i)
                     + (`TX_BURST_W+1)'(rd_addr_q == '0);

  // Last beat of the final burst frame is being read
  assign burst_done = (burst_len_q != '0) && (rd_addr_q == frame_depth_q) &&
                      (frames_seen == {1'b0, burst_len_q});

  always_ff @(posedge dac_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= AWG_IDLE;
      rd_addr_q   <= '0;
      frame_cnt_q <= '0;
    end else begin
      case (state_q)
        AWG_IDLE: begin
          rd_addr_q   <= '0;
          frame_cnt_q <= '0;
          if (cmd_start && !cmd_stop) begin
            state_q <= AWG_PLAY;
          end
        end
        AWG_PLAY: begin
          // Tracks the player read address
          rd_addr_q <= (rd_addr_q == frame_depth_q) ? '0 : rd_addr_q + 1'b1;
          if (frame_start_i) begin
            frame_cnt_q <= frame_cnt_q + 1'b1;
          end
          if (cmd_stop || burst_done) begin
            state_q <= AWG_IDLE;
          end
        end
        default: state_q <= AWG_IDLE;
      endcase
    end
  end

  // Trigger one cycle behind frame start
  always_ff @(posedge dac_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trigger_o <= 1'b0;
    end else begin
      trigger_o <= frame_start_i && trig_en_q;
    end
  end

  assign awg_run_o         = (state_q == AWG_PLAY);
  assign busy_o            = awg_run_o;
  assign frame_last_addr_o = frame_depth_q;

endmodule

`default_nettype wire

// ==== source/tx_pkg.sv ====
// Types of the transmit chain: register map, AWG state and the beat structs
// Modules refer to these by scoped name in ports and by import in their bodies
`default_nettype none
`include "tx_consts.svh"

package tx_pkg;

  // Register port addresses
  typedef enum logic [3:0] {
    REG_PHASE_INC0  = 4'd0,
    REG_PHASE_INC1  = 4'd1,
    REG_SCALE0      = 4'd2,
    REG_SCALE1      = 4'd3,
    REG_MUX_SEL     = 4'd4,  // 2 bits per channel
    REG_TRIG_EN     = 4'd5,
    REG_FRAME_DEPTH = 4'd6,  // beats minus one
    REG_BURST_LEN   = 4'd7,  // frames, 0 runs continuously
    REG_AWG_CMD     = 4'd8   // bit 0 start, bit 1 stop
  } tx_reg_e;

  // AWG sequencer
  typedef enum logic {
    AWG_IDLE = 1'b0,
    AWG_PLAY = 1'b1
  } awg_state_e;

  typedef logic signed [`TX_SAMPLE_W-1:0] sample_t;

  // One channel beat, sample 0 in the low bits
  typedef struct packed {
    logic                          valid;
    sample_t [`TX_PAR_SAMPLES-1:0] data;
  } tx_beat_t;

  // Datapath configuration
  typedef struct packed {
    logic [`TX_CHANNELS-1:0][`TX_PHASE_W-1:0]   phase_inc;
    logic [`TX_CHANNELS-1:0][`TX_SCALE_W-1:0]   scale;
    logic [`TX_CHANNELS-1:0][`TX_MUX_SEL_W-1:0] mux_sel;
    logic [`TX_CHANNELS-1:0]                    phase_rst;
  } tx_cfg_t;

  // AWG memory write
  typedef struct packed {
    logic                          strobe;
    logic [`TX_CH_W-1:0]           channel;
    logic [`TX_AWG_ADDR_W-1:0]     addr;
    sample_t [`TX_PAR_SAMPLES-1:0] data;
  } awg_wr_t;

endpackage

`default_nettype wire

// ==== src.f ====
+incdir+source
source/tx_pkg.sv
source/tx_ctrl.sv
source/awg_player.sv
source/dds_sawtooth.sv
source/channel_mux.sv
source/dac_prescaler.sv
source/transmit_top.sv
tb/tb_clk_gen.sv
tb/tb_transmit_top.sv

// ==== tb/tb_clk_gen.sv ====
// Testbench clock and reset source
// 4 ns clock, active low reset held for the first 3 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Free running clock, first rising edge at 2 ns
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release on a rising edge after 3 cycles
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/tb_transmit_top.sv ====
// Self checking testbench for the DAC transmit chain
// Random register and AWG traffic, compared every cycle with a cycle based model
`timescale 1ns/1ps
`default_nettype none
`include "tx_consts.svh"

module tb_transmit_top;
  import tx_pkg::*;

  localparam int CYCLE_LIMIT = 2500;

  wire                              clk;
  wire                              rst_n;
  logic                             reg_wr;
  tx_reg_e                          reg_addr;
  logic [31:0]                      reg_wdata;
  awg_wr_t                          awg_wr;
  wire tx_beat_t [`TX_CHANNELS-1:0] dac_data;
  wire                              dac_trigger;
  wire                              awg_busy;

  // Model state
  logic [`TX_CHANNELS-1:0][31:0]    m_inc;
  logic [`TX_CHANNELS-1:0][17:0]    m_scale;
  logic [`TX_CHANNELS-1:0][1:0]     m_sel;
  logic                             m_trig_en;
  logic [5:0]                       m_depth;
  logic [15:0]                      m_burst;
  logic [31:0]                      m_mem [`TX_CHANNELS][`TX_AWG_DEPTH];
  logic [`TX_CHANNELS-1:0][31:0]    m_phase;
  logic                             m_busy;
  logic [5:0]                       m_addr;
  int                               m_frames;
  logic                             m_fs;
  logic                             m_trig;
  tx_beat_t [`TX_CHANNELS-1:0]      m_awg;
  tx_beat_t [`TX_CHANNELS-1:0]      m_dds;
  tx_beat_t [`TX_CHANNELS-1:0]      m_mux;
  tx_beat_t [`TX_CHANNELS-1:0]      m_out;

  wire  start_cmd = reg_wr && (reg_addr == REG_AWG_CMD) && reg_wdata[0];
  wire  stop_cmd  = reg_wr && (reg_addr == REG_AWG_CMD) && reg_wdata[1];

  int   seed;
  int   cycle_count;
  int   beat_count;
  int   trig_count;
  int   depth;
  int   beats_before;
  int   trigs_before;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  transmit_top i_dut (
    .dac_clk_i     (clk),
    .rst_n_i       (rst_n),
    .reg_wr_i      (reg_wr),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .awg_wr_i      (awg_wr),
    .dac_data_o    (dac_data),
    .dac_trigger_o (dac_trigger),
    .awg_busy_o    (awg_busy)
  );

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  // Sawtooth sample k is the phase top bits, k increments ahead
  function automatic sample_t saw_sample(input logic [31:0] phase,
                                         input logic [31:0] inc, input int k);
    logic [31:0] p;
    p = phase + inc * 32'(k);
    return p[31:16];
  endfunction

  // Signed gain, floor of product over 2^16, clamped to 16 bits
  function automatic sample_t gain_sample(input sample_t s, input logic [17:0] scale);
    longint p;
    p = longint'(s) * longint'($signed(scale));
    p = p >>> 16;
    if (p > 32767) p = 32767;
    if (p < -32768) p = -32768;
    return sample_t'(p);
  endfunction

  // All stimulus tasks start and end just after a rising edge
  task automatic write_reg(input tx_reg_e addr, input logic [31:0] data);
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_wr    <= 1'b0;
  endtask

  task automatic load_awg(input logic ch, input logic [5:0] addr, input logic [31:0] data);
    awg_wr.strobe  <= 1'b1;
    awg_wr.channel <= ch;
    awg_wr.addr    <= addr;
    awg_wr.data    <= data;
    @(posedge clk);
    awg_wr.strobe  <= 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Busy is sampled away from the clock edge
  task automatic wait_idle;
    @(negedge clk);
    while (awg_busy) @(negedge clk);
    @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_inc     <= '0;
      m_scale   <= '0;
      m_sel     <= '0;
      m_trig_en <= 1'b0;
      m_depth   <= '0;
      m_burst   <= '0;
      m_phase   <= '0;
      m_busy    <= 1'b0;
      m_addr    <= '0;
      m_frames  <= 0;
      m_fs      <= 1'b0;
      m_trig    <= 1'b0;
      m_awg     <= '0;
      m_dds     <= '0;
      m_mux     <= '0;
      m_out     <= '0;
    end else begin : step
      int frames_now;
      // Register port
      if (reg_wr) begin
        case (reg_addr)
          REG_PHASE_INC0:  m_inc[0] <= reg_wdata;
          REG_PHASE_INC1:  m_inc[1] <= reg_wdata;
          REG_SCALE0:      m_scale[0] <= reg_wdata[17:0];
          REG_SCALE1:      m_scale[1] <= reg_wdata[17:0];
          REG_MUX_SEL: begin
            m_sel[0] <= reg_wdata[1:0];
            m_sel[1] <= reg_wdata[3:2];
          end
          REG_TRIG_EN:     m_trig_en <= reg_wdata[0];
          REG_FRAME_DEPTH: m_depth <= reg_wdata[5:0];
          REG_BURST_LEN:   m_burst <= reg_wdata[15:0];
          default: ;
        endcase
      end
      if (awg_wr.strobe) begin
        m_mem[awg_wr.channel][awg_wr.addr] <= awg_wr.data;
      end
      // DDS, beat from the phase before the two sample advance
      for (int c = 0; c < `TX_CHANNELS; c++) begin
        m_dds[c].valid <= 1'b1;
        for (int k = 0; k < `TX_PAR_SAMPLES; k++) begin
          m_dds[c].data[k] <= saw_sample(m_phase[c], m_inc[c], k);
        end
        if (reg_wr && (reg_addr == ((c == 0) ? REG_PHASE_INC0 : REG_PHASE_INC1))) begin
          m_phase[c] <= '0;
        end else begin
          m_phase[c] <= m_phase[c] + 32'd2 * m_inc[c];
        end
      end
      // AWG sequencer and player
      if (m_busy) begin
        frames_now = m_frames + ((m_addr == 6'd0) ? 1 : 0);
        m_frames <= frames_now;
        m_addr   <= (m_addr == m_depth) ? 6'd0 : m_addr + 6'd1;
        m_fs     <= (m_addr == 6'd0);
        for (int c = 0; c < `TX_CHANNELS; c++) begin
          m_awg[c] <= {1'b1, m_mem[c][m_addr]};
        end
        if (stop_cmd || ((m_burst != 16'd0) && (m_addr == m_depth) &&
                         (frames_now == int'(m_burst)))) begin
          m_busy <= 1'b0;
        end
      end else begin
        m_frames <= 0;
        m_addr   <= '0;
        m_fs     <= 1'b0;
        m_awg    <= '0;
        if (start_cmd && !stop_cmd) m_busy <= 1'b1;
      end
      m_trig <= m_fs && m_trig_en;
      // Mux stage, then gain stage
      for (int c = 0; c < `TX_CHANNELS; c++) begin
        m_mux[c] <= (m_sel[c] < 2'd2) ? m_awg[m_sel[c][0]] : m_dds[m_sel[c][0]];
        m_out[c].valid <= m_mux[c].valid;
        for (int k = 0; k < `TX_PAR_SAMPLES; k++) begin
          m_out[c].data[k] <= gain_sample(m_mux[c].data[k], m_scale[c]);
        end
      end
    end
  end

  // Compare every output on the falling edge once out of reset
  always @(negedge clk) begin
    if (rst_n) begin
      for (int c = 0; c < `TX_CHANNELS; c++) begin
        check_value($sformatf("dac_data_o[%0d].valid", c), 64'(dac_data[c].valid),
                    64'(m_out[c].valid));
        check_value($sformatf("dac_data_o[%0d].data", c), 64'(dac_data[c].data),
                    64'(m_out[c].data));
      end
      check_value("dac_trigger_o", 64'(dac_trigger), 64'(m_trig));
      check_value("awg_busy_o", 64'(awg_busy), 64'(m_busy));
      if (dac_trigger) trig_count <= trig_count + 1;
      if (dac_data[0].valid) beat_count <= beat_count + 1;
    end
  end

  // Run limit, about twice the test length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////
  initial begin
    seed        = 90;
    cycle_count = 0;
    beat_count  = 0;
    trig_count  = 0;
    reg_wr      = 1'b0;
    reg_addr    = REG_PHASE_INC0;
    reg_wdata   = '0;
    awg_wr      = '0;
    wait (rst_n);
    @(posedge clk);

    // Reset values, zero scale gives zero data
    wait_cycles(4);
    @(negedge clk);
    for (int c = 0; c < `TX_CHANNELS; c++) begin
      check_value($sformatf("dac_data_o[%0d].valid", c), 64'(dac_data[c].valid), 64'd0);
      check_value($sformatf("dac_data_o[%0d].data", c), 64'(dac_data[c].data), 64'd0);
    end
    check_value("awg_busy_o", 64'(awg_busy), 64'd0);
    check_value("dac_trigger_o", 64'(dac_trigger), 64'd0);
    @(posedge clk);

    // Running DDS through zero gain stays at zero
    write_reg(REG_MUX_SEL, 32'h0000_000e);
    write_reg(REG_PHASE_INC0, $random(seed));
    write_reg(REG_PHASE_INC1, $random(seed));
    wait_cycles(4);
    @(negedge clk);
    for (int c = 0; c < `TX_CHANNELS; c++) begin
      check_value($sformatf("dac_data_o[%0d].valid", c), 64'(dac_data[c].valid), 64'd1);
      check_value($sformatf("dac_data_o[%0d].data", c), 64'(dac_data[c].data), 64'd0);
    end
    @(posedge clk);

    // DDS straight through at unity gain
    write_reg(REG_SCALE0, 32'd65536);
    write_reg(REG_SCALE1, 32'd65536);
    repeat (2) begin
      write_reg(REG_PHASE_INC0, $random(seed));
      write_reg(REG_PHASE_INC1, $random(seed));
      wait_cycles(50);
    end

    // Random routing, then both channels on one source
    repeat (8) begin
      write_reg(REG_MUX_SEL, $random(seed) & 32'hf);
      wait_cycles(12);
    end
    write_reg(REG_MUX_SEL, 32'h0000_000a);
    wait_cycles(12);

    // Gains near +2.0 and -2.0 saturate, then random gains
    write_reg(REG_MUX_SEL, 32'h0000_000e);
    write_reg(REG_SCALE0, 32'h0001_ffff);
    write_reg(REG_SCALE1, 32'h0002_0000);
    wait_cycles(16);
    repeat (10) begin
      write_reg(REG_SCALE0, $random(seed) & 32'h3_ffff);
      write_reg(REG_SCALE1, $random(seed) & 32'h3_ffff);
      wait_cycles(16);
    end

    // AWG burst of 3 frames
    for (int c = 0; c < `TX_CHANNELS; c++) begin
      for (int a = 0; a < `TX_AWG_DEPTH; a++) begin
        load_awg(1'(c), 6'(a), $random(seed));
      end
    end
    depth = $random(seed) & 32'h3f;
    write_reg(REG_MUX_SEL, 32'h0000_0004);
    write_reg(REG_SCALE0, 32'd65536);
    write_reg(REG_SCALE1, 32'd65536);
    write_reg(REG_FRAME_DEPTH, 32'(depth));
    write_reg(REG_BURST_LEN, 32'd3);
    write_reg(REG_TRIG_EN, 32'd1);
    wait_cycles(4);
    beats_before = beat_count;
    trigs_before = trig_count;
    write_reg(REG_AWG_CMD, 32'd1);
    wait_idle();
    wait_cycles(6);
    check_value("dac_data_o[0].valid beats in burst", 64'(beat_count - beats_before),
                64'(3 * (depth + 1)));
    check_value("dac_trigger_o pulses", 64'(trig_count - trigs_before), 64'd3);

    // Same burst with the trigger off
    write_reg(REG_TRIG_EN, 32'd0);
    beats_before = beat_count;
    trigs_before = trig_count;
    write_reg(REG_AWG_CMD, 32'd1);
    wait_idle();
    wait_cycles(6);
    check_value("dac_data_o[0].valid beats in burst", 64'(beat_count - beats_before),
                64'(3 * (depth + 1)));
    check_value("gated dac_trigger_o pulses", 64'(trig_count - trigs_before), 64'd0);

    // Continuous play ended by a stop command
    write_reg(REG_BURST_LEN, 32'd0);
    write_reg(REG_TRIG_EN, 32'd1);
    trigs_before = trig_count;
    write_reg(REG_AWG_CMD, 32'd1);
    wait_cycles(100 + ($random(seed) & 32'h3f));
    write_reg(REG_AWG_CMD, 32'd2);
    wait_idle();
    wait_cycles(6);
    check_value("dac_trigger_o pulses seen in continuous play",
                64'(trig_count > trigs_before), 64'd1);

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
